// ==== source/udma_defines.svh ====
/*
 * micro-DMA sizing and register select layout
 * the channel count is tied to the 2-bit channel field of regsel
 * changing UDMA_CHANNELS alone is not supported
 */
`ifndef UDMA_DEFINES_SVH
`define UDMA_DEFINES_SVH

`define UDMA_CHANNELS 4             // fixed by regsel[3:2]
`define UDMA_DW 32                  // bus data width
`define UDMA_AW 32                  // byte address width

// regsel layout {group[1:0], channel[1:0], lane[1:0]}
`define UDMA_SEL_GROUP_LSB 4
`define UDMA_SEL_CH_LSB 2

`endif

// ==== source/udma_reg_pkg.sv ====
/*
 * CPU register map of the micro-DMA
 * group codes follow regsel[5:4]; the NEST group is read only
 * regwe is expected one-hot, wider writes take precedence otherwise
 */
`default_nettype none

package udma_reg_pkg;

    typedef enum logic [1:0] {
        GRP_SRC      = 2'd0,    // source address
        GRP_DST      = 2'd1,    // destination address
        GRP_CNT_MODE = 2'd2,    // {8'd0, mode, count}
        GRP_NEST     = 2'd3     // interrupt nesting counter
    } reg_group_t;

    typedef enum logic [1:0] {
        WR_LONG,
        WR_WORD,
        WR_BYTE,
        WR_NONE
    } reg_width_t;

    // regwe[2] long, [1] word, [0] byte
    function automatic reg_width_t decode_width(input logic [2:0] we);
        if (we[2]) return WR_LONG;
        if (we[1]) return WR_WORD;
        if (we[0]) return WR_BYTE;
        return WR_NONE;
    endfunction

endpackage

`default_nettype wire

// ==== source/udma_xfer_pkg.sv ====
/*
 * transfer encodings of the micro-DMA mode byte
 * mode[1:0] item size, mode[4:2] address mode, upper bits unused
 * reserved address modes 6 and 7 behave as FIXED
 */
`default_nettype none

package udma_xfer_pkg;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_WORD = 2'd1,
        SZ_LONG = 2'd2,
        SZ_RSVD = 2'd3          // handled as long
    } item_size_t;

    typedef enum logic [2:0] {
        AM_DST_INC = 3'd0,
        AM_DST_DEC = 3'd1,
        AM_SRC_INC = 3'd2,
        AM_SRC_DEC = 3'd3,
        AM_FIXED   = 3'd4,
        AM_COUNT   = 3'd5,      // no bus cycle, src += 1
        AM_RSV6    = 3'd6,
        AM_RSV7    = 3'd7
    } addr_mode_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_READ,
        ST_WRITE,
        ST_UPDATE
    } eng_state_t;

    // bytes per item, used for address stepping
    function automatic logic [2:0] item_bytes(input item_size_t sz);
        case (sz)
            SZ_BYTE: return 3'd1;
            SZ_WORD: return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== source/udma_regs.sv ====
/*
 * micro-DMA channel register file, four channels
 * partial writes land on the lane given by regsel[1:0], regout lags one cen cycle
 * a CPU write beats an engine update on the addressed register
 * do not write a channel while it has requests pending
 */
`timescale 1ns/100ps
`default_nettype none
`include "udma_defines.svh"

module udma_regs (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 cen,
    // CPU port
    input  wire [`UDMA_DW-1:0]  regin,
    input  wire [5:0]           regsel,
    input  wire [2:0]           regwe,
    input  wire                 int_inc,
    input  wire                 int_dec,
    output logic [`UDMA_DW-1:0] regout,
    // engine port
    input  wire [1:0]           eng_ch,
    input  wire                 upd,
    input  wire [`UDMA_AW-1:0]  new_src,
    input  wire [`UDMA_AW-1:0]  new_dst,
    input  wire [15:0]          new_cnt,
    output logic [`UDMA_AW-1:0] cur_src,
    output logic [`UDMA_AW-1:0] cur_dst,
    output logic [15:0]         cur_cnt,
    output logic [7:0]          cur_mode
);
    import udma_reg_pkg::*;

    logic [`UDMA_AW-1:0] sreg [0:`UDMA_CHANNELS-1];    // source addresses
    logic [`UDMA_AW-1:0] dreg [0:`UDMA_CHANNELS-1];    // destination addresses
    logic [15:0]         dmac [0:`UDMA_CHANNELS-1];    // item counts
    logic [7:0]          dmam [0:`UDMA_CHANNELS-1];    // mode bytes
    logic [15:0]         intnest;                      // nesting counter

    reg_group_t          grp;
    reg_width_t          wr_width;
    logic [1:0]          ch;
    logic [1:0]          lane;
    logic [`UDMA_DW-1:0] cm_old;    // count/mode word as the CPU sees it
    logic [`UDMA_DW-1:0] cm_new;

    // overlay the written lanes of din onto old
    function automatic logic [`UDMA_DW-1:0] merge_word(
        input logic [`UDMA_DW-1:0] old,
        input logic [`UDMA_DW-1:0] din,
        input reg_width_t          w,
        input logic [1:0]          ln
    );
        logic [`UDMA_DW-1:0] res;
        res = old;
        case (w)
            WR_LONG: res = din;
            WR_WORD: res[{ln[1], 4'd0} +: 16] = din[15:0];     // half picked by ln[1]
            WR_BYTE: res[{ln, 3'd0} +: 8] = din[7:0];
            default: ;
        endcase
        return res;
    endfunction

    assign grp      = reg_group_t'(regsel[`UDMA_SEL_GROUP_LSB +: 2]);
    assign ch       = regsel[`UDMA_SEL_CH_LSB +: 2];
    assign lane     = regsel[1:0];
    assign wr_width = decode_width(regwe);

    // word write to the upper half or byte lane 2 reaches the mode byte
    assign cm_old = {8'd0, dmam[ch], dmac[ch]};
    assign cm_new = merge_word(cm_old, regin, wr_width, lane);

    // engine view of the selected channel
    assign cur_src  = sreg[eng_ch];
    assign cur_dst  = dreg[eng_ch];
    assign cur_cnt  = dmac[eng_ch];
    assign cur_mode = dmam[eng_ch];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `UDMA_CHANNELS; i++) begin
                sreg[i] <= '0;
                dreg[i] <= '0;
                dmac[i] <= '0;
                dmam[i] <= '0;
            end
            intnest <= '0;
        end else if (cen) begin
            case ({int_inc, int_dec})
                2'b10:   intnest <= intnest + 16'd1;
                2'b01:   intnest <= intnest - 16'd1;
                default: ;                          // both or none, hold
            endcase
            if (upd) begin                          // engine write back
                sreg[eng_ch] <= new_src;
                dreg[eng_ch] <= new_dst;
                dmac[eng_ch] <= new_cnt;
            end
            if (wr_width != WR_NONE) begin          // later assignment wins over upd
                case (grp)
                    GRP_SRC: sreg[ch] <= merge_word(sreg[ch], regin, wr_width, lane);
                    GRP_DST: dreg[ch] <= merge_word(dreg[ch], regin, wr_width, lane);
                    GRP_CNT_MODE: begin
                        dmam[ch] <= cm_new[23:16];
                        dmac[ch] <= cm_new[15:0];   // byte lane 3 falls off
                    end
                    default: ;                      // nesting counter not writable
                endcase
            end
        end
    end

    // registered read mux
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regout <= '0;
        end else if (cen) begin
            case (grp)
                GRP_SRC:      regout <= sreg[ch];
                GRP_DST:      regout <= dreg[ch];
                GRP_CNT_MODE: regout <= cm_old;
                default:      regout <= {16'd0, intnest};
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/udma_engine.sv ====
/*
 * micro-DMA transfer engine, one item per request, channel 0 first
 * Wishbone classic master, ack is only sampled on cen cycles
 * addresses must be aligned to the item size
 * a count of zero at start wraps to 16'hffff and gives no dma_end
 */
`timescale 1ns/100ps
`default_nettype none
`include "udma_defines.svh"

module udma_engine (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        cen,
    input  wire [`UDMA_CHANNELS-1:0]   req,
    // register file side
    output logic [1:0]                 eng_ch,
    input  wire [`UDMA_AW-1:0]         cur_src,
    input  wire [`UDMA_AW-1:0]         cur_dst,
    input  wire [15:0]                 cur_cnt,
    input  wire [7:0]                  cur_mode,
    output logic                       upd,
    output logic [`UDMA_AW-1:0]        new_src,
    output logic [`UDMA_AW-1:0]        new_dst,
    output logic [15:0]                new_cnt,
    output logic                       busy,
    output logic [`UDMA_CHANNELS-1:0]  dma_end,
    // Wishbone master
    output logic                       wb_cyc,
    output logic                       wb_stb,
    output logic                       wb_we,
    output logic [`UDMA_AW-1:0]        wb_adr,
    output logic [`UDMA_DW-1:0]        wb_dat_o,
    output logic [`UDMA_DW/8-1:0]      wb_sel,
    input  wire [`UDMA_DW-1:0]         wb_dat_i,
    input  wire                        wb_ack
);
    import udma_xfer_pkg::*;

    eng_state_t                state;
    logic [`UDMA_CHANNELS-1:0] pend;        // latched requests
    logic [`UDMA_CHANNELS-1:0] req_all;
    logic [`UDMA_CHANNELS-1:0] pick_oh;
    logic [`UDMA_CHANNELS-1:0] ch_oh;
    logic [1:0]                pick_ch;
    logic [1:0]                ch_q;
    logic [`UDMA_AW-1:0]       src_q;
    logic [`UDMA_AW-1:0]       dst_q;
    logic [15:0]               cnt_q;
    logic [7:0]                mode_q;
    item_size_t                size_q;
    addr_mode_t                amode_q;
    logic [`UDMA_AW-1:0]       step;

    function automatic logic [3:0] lane_sel(input item_size_t sz, input logic [1:0] a);
        case (sz)
            SZ_BYTE: return 4'b0001 << a;
            SZ_WORD: return a[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    // pick the item out of its lanes, right aligned
    function automatic logic [31:0] rd_item(input logic [31:0] d, input item_size_t sz,
                                            input logic [1:0] a);
        case (sz)
            SZ_BYTE: return {24'd0, d[{a, 3'd0} +: 8]};
            SZ_WORD: return {16'd0, d[{a[1], 4'd0} +: 16]};
            default: return d;
        endcase
    endfunction

    function automatic logic [31:0] wr_lanes(input logic [31:0] it, input item_size_t sz);
        case (sz)
            SZ_BYTE: return {4{it[7:0]}};
            SZ_WORD: return {2{it[15:0]}};
            default: return it;
        endcase
    endfunction

    assign req_all = pend | req;
    always_comb begin
        pick_ch = 2'd0;
        for (int i = `UDMA_CHANNELS - 1; i >= 0; i--) begin
            if (req_all[i]) pick_ch = i[1:0];   // lowest set bit wins
        end
    end
    assign pick_oh = {{(`UDMA_CHANNELS-1){1'b0}}, 1'b1} << pick_ch;
    assign ch_oh   = {{(`UDMA_CHANNELS-1){1'b0}}, 1'b1} << ch_q;

    assign eng_ch  = ch_q;
    assign size_q  = item_size_t'(mode_q[1:0]);
    assign amode_q = addr_mode_t'(mode_q[4:2]);
    assign step    = {{(`UDMA_AW-3){1'b0}}, item_bytes(size_q)};
    assign upd     = state == ST_UPDATE;
    assign busy    = state != ST_IDLE;
    assign dma_end = (upd && cen && new_cnt == 16'd0) ? ch_oh : '0;

    always_comb begin
        new_src = src_q;
        new_dst = dst_q;
        new_cnt = cnt_q - 16'd1;
        case (amode_q)
            AM_DST_INC: new_dst = dst_q + step;
            AM_DST_DEC: new_dst = dst_q - step;
            AM_SRC_INC: new_src = src_q + step;
            AM_SRC_DEC: new_src = src_q - step;
            AM_COUNT:   new_src = src_q + {{(`UDMA_AW-1){1'b0}}, 1'b1};
            default:    ;                           // fixed and reserved
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= ST_IDLE;
            pend   <= '0;
            ch_q   <= 2'd0;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end else if (cen) begin
            pend <= req_all;                        // repeat pulses merge
            case (state)
                ST_IDLE: if (|req_all) begin
                    pend  <= req_all & ~pick_oh;
                    ch_q  <= pick_ch;
                    state <= ST_LOAD;
                end
                ST_LOAD: if (addr_mode_t'(cur_mode[4:2]) == AM_COUNT) begin
                    state <= ST_UPDATE;             // no bus cycle
                end else begin
                    wb_cyc <= 1'b1;
                    wb_stb <= 1'b1;
                    wb_we  <= 1'b0;
                    state  <= ST_READ;
                end
                ST_READ: if (wb_ack) begin
                    wb_cyc <= 1'b0;
                    wb_stb <= 1'b0;
                    state  <= ST_WRITE;
                end
                ST_WRITE: if (!wb_cyc) begin        // idle cycle between bus cycles
                    wb_cyc <= 1'b1;
                    wb_stb <= 1'b1;
                    wb_we  <= 1'b1;
                end else if (wb_ack) begin
                    wb_cyc <= 1'b0;
                    wb_stb <= 1'b0;
                    wb_we  <= 1'b0;
                    state  <= ST_UPDATE;
                end
                default: state <= ST_IDLE;          // UPDATE lasts one cycle
            endcase
        end
    end

    // transfer payload, stable while wb_cyc is high
    always_ff @(posedge clk) begin
        if (cen && state == ST_LOAD) begin
            src_q  <= cur_src;
            dst_q  <= cur_dst;
            cnt_q  <= cur_cnt;
            mode_q <= cur_mode;
            wb_adr <= cur_src;
            wb_sel <= lane_sel(item_size_t'(cur_mode[1:0]), cur_src[1:0]);
        end
        if (cen && state == ST_READ && wb_ack) begin
            wb_adr   <= dst_q;
            wb_sel   <= lane_sel(size_q, dst_q[1:0]);
            wb_dat_o <= wr_lanes(rd_item(wb_dat_i, size_q, src_q[1:0]), size_q);
        end
    end

endmodule

`default_nettype wire

// ==== source/udma_top.sv ====
/*
 * micro-DMA top, register file plus transfer engine
 * req bits are one cen cycle pulses, busy falls when an item is done
 */
`timescale 1ns/100ps
`default_nettype none
`include "udma_defines.svh"

module udma_top (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        cen,
    input  wire [`UDMA_DW-1:0]         regin,
    input  wire [5:0]                  regsel,
    input  wire [2:0]                  regwe,
    input  wire                        int_inc,
    input  wire                        int_dec,
    output logic [`UDMA_DW-1:0]        regout,
    input  wire [`UDMA_CHANNELS-1:0]   req,
    output logic [`UDMA_CHANNELS-1:0]  dma_end,
    output logic                       busy,
    output logic                       wb_cyc,
    output logic                       wb_stb,
    output logic                       wb_we,
    output logic [`UDMA_AW-1:0]        wb_adr,
    output logic [`UDMA_DW-1:0]        wb_dat_o,
    output logic [`UDMA_DW/8-1:0]      wb_sel,
    input  wire [`UDMA_DW-1:0]         wb_dat_i,
    input  wire                        wb_ack
);
    logic [1:0]          eng_ch;        // channel under service
    logic                upd;
    logic [`UDMA_AW-1:0] cur_src, cur_dst, new_src, new_dst;
    logic [15:0]         cur_cnt, new_cnt;
    logic [7:0]          cur_mode;

    udma_regs u_regs (
        .clk, .rst, .cen, .regin, .regsel, .regwe, .int_inc, .int_dec, .regout,
        .eng_ch, .upd, .new_src, .new_dst, .new_cnt,
        .cur_src, .cur_dst, .cur_cnt, .cur_mode
    );

    udma_engine u_engine (
        .clk, .rst, .cen, .req,
        .eng_ch, .cur_src, .cur_dst, .cur_cnt, .cur_mode,
        .upd, .new_src, .new_dst, .new_cnt, .busy, .dma_end,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_o, .wb_sel, .wb_dat_i, .wb_ack
    );

endmodule

`default_nettype wire

// ==== bench/udma_mem_model.sv ====
/*
 * Wishbone classic slave memory for the micro-DMA testbench
 * 1 KB, byte address bits 9:2 pick the word, upper bits ignored
 * 0 to 3 random wait states per cycle, ack lasts one clock
 */
`timescale 1ns/100ps
`default_nettype none

module udma_mem_model (
    input  wire         clk,
    input  wire         rst,
    input  wire         cyc,
    input  wire         stb,
    input  wire         we,
    input  wire  [31:0] adr,
    input  wire  [31:0] dat_i,
    input  wire  [3:0]  sel,
    output logic [31:0] dat_o,
    output logic        ack
);
    localparam int WORDS = 256;

    logic [31:0] mem [0:WORDS-1];
    logic [7:0]  idx;
    logic [1:0]  wait_left;         // wait states still to insert
    integer      seed;

    assign idx = adr[9:2];

    initial begin
        seed = 32'h817a;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = {8'(i) ^ 8'h5a, ~8'(i), 8'(i) + 8'h21, 8'(i)};   // unique per word
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            ack       <= 1'b0;
            dat_o     <= '0;
            wait_left <= 2'd1;
        end else if (ack) begin
            ack       <= 1'b0;                  // master drops cyc on this edge
            wait_left <= 2'($random(seed));
        end else if (cyc && stb) begin
            if (wait_left == 2'd0) begin
                ack   <= 1'b1;
                dat_o <= mem[idx];
                if (we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (sel[b]) mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
                    end
                end
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/udma_tb.sv ====
/*
 * micro-DMA testbench with cen tied high and inputs changed on the falling edge
 * table entries program one channel and issue single-item requests
 * a reference copy of memory and of the channel registers predicts results
 */
`timescale 1ns/100ps
`default_nettype none
`include "udma_defines.svh"

module udma_tb;
    import udma_reg_pkg::*;
    import udma_xfer_pkg::*;

    localparam int PERIOD       = 40;
    localparam int NUM_ENTRIES  = 10;
    localparam int ENTRY_CYCLES = 120;      // programming plus up to 4 items and read back
    localparam int WATCHDOG_NS  = (NUM_ENTRIES + 2) * ENTRY_CYCLES * 2 * PERIOD;

    typedef struct packed {
        logic [1:0]  ch;
        logic [7:0]  mode;
        logic [31:0] src;
        logic [31:0] dst;
        logic [15:0] cnt;
        logic [3:0]  nreq;
    } entry_t;

    logic clk, rst, cen, int_inc, int_dec, busy;
    logic [`UDMA_DW-1:0] regin, regout, wb_dat_o, wb_dat_i;
    logic [`UDMA_AW-1:0] wb_adr;
    logic [5:0] regsel;
    logic [2:0] regwe;
    logic [`UDMA_CHANNELS-1:0] req, dma_end;
    logic [3:0] wb_sel;
    logic wb_cyc, wb_stb, wb_we, wb_ack;

    logic [31:0] exp_mem [0:255];           // reference memory
    logic [31:0] m_src [0:3];
    logic [31:0] m_dst [0:3];
    logic [23:0] m_cm [0:3];                // {mode, count}
    logic [31:0] wr_q [$];                  // write addresses in bus order
    logic [3:0]  end_seen;
    logic        ack_prev;                  // ack seen at the last falling edge
    int errors, end_cycles, cyc_cycles;

    udma_top DUT (.*);

    udma_mem_model mem_i (
        .clk, .rst, .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
        .dat_i(wb_dat_o), .sel(wb_sel), .dat_o(wb_dat_i), .ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    always @(negedge clk) begin             // bus and dma_end monitor
        if (dma_end != '0) begin
            end_cycles++;
            end_seen |= dma_end;
        end
        if (wb_cyc) cyc_cycles++;
        if (wb_cyc && wb_stb && wb_we && wb_ack) wr_q.push_back(wb_adr);
        if (wb_stb && !wb_cyc) report_error("wb_stb high without wb_cyc");
        if (ack_prev && wb_cyc) report_error("wb_cyc still high the cycle after wb_ack");
        if ((wb_cyc || dma_end != '0) && !busy) begin
            report_error("busy low while a transfer is active");
        end
        ack_prev = wb_ack;
    end

    initial begin
        eng_state_t st;
        #(WATCHDOG_NS);
        st = DUT.u_engine.state;
        $display("watchdog expired after %0d ns with the engine in %s", WATCHDOG_NS, st.name());
        $display("Errors found");
        $finish;
    end

    // ch, mode {amode, size}, src, dst, count, requests
    function automatic entry_t table_entry(input int i);
        case (i)
            0: return '{2'd0, 8'h00, 32'h013, 32'h200, 16'd3, 4'd3};   // dst inc with bytes
            1: return '{2'd1, 8'h05, 32'h042, 32'h216, 16'd2, 4'd2};   // dst dec with words
            2: return '{2'd2, 8'h0a, 32'h080, 32'h220, 16'd4, 4'd2};   // src inc longs and no end
            3: return '{2'd3, 8'h0c, 32'h0a7, 32'h231, 16'd2, 4'd2};   // src dec with bytes
            4: return '{2'd0, 8'h09, 32'h0c0, 32'h23a, 16'd3, 4'd3};
            5: return '{2'd1, 8'h02, 32'h104, 32'h240, 16'd2, 4'd2};
            6: return '{2'd2, 8'h12, 32'h108, 32'h250, 16'd2, 4'd2};   // fixed
            7: return '{2'd3, 8'h14, 32'h300, 32'h260, 16'd3, 4'd3};   // count mode without bus
            8: return '{2'd1, 8'h0e, 32'h11c, 32'h270, 16'd1, 4'd1};
            default: return '{2'd2, 8'h04, 32'h12d, 32'h283, 16'd2, 4'd2};
        endcase
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    function automatic logic [7:0] get_byte(input logic [31:0] a);
        return exp_mem[a[9:2]][{a[1:0], 3'b000} +: 8];
    endfunction

    function automatic void put_byte(input logic [31:0] a, input logic [7:0] b);
        exp_mem[a[9:2]][{a[1:0], 3'b000} +: 8] = b;
    endfunction

    task automatic clear_monitors;
        end_seen   = '0;
        end_cycles = 0;
        cyc_cycles = 0;
        wr_q.delete();
    endtask

    // CPU write mirrored into the reference registers
    task automatic write_reg(input reg_group_t g, input logic [1:0] ch,
                             input logic [1:0] lane, input logic [2:0] we,
                             input logic [31:0] d);
        logic [31:0] mask, val, cm;
        @(negedge clk);
        regsel = {g, ch, lane};
        regin  = d;
        regwe  = we;
        @(negedge clk);
        regwe  = 3'b000;
        mask = we[2] ? 32'hffffffff : we[1] ? (32'h0000ffff << (16 * lane[1]))
                                            : (32'h000000ff << (8 * lane));
        val  = we[2] ? d : we[1] ? {2{d[15:0]}} : {4{d[7:0]}};
        cm   = ({8'd0, m_cm[ch]} & ~mask) | (val & mask);
        case (g)
            GRP_SRC:      m_src[ch] = (m_src[ch] & ~mask) | (val & mask);
            GRP_DST:      m_dst[ch] = (m_dst[ch] & ~mask) | (val & mask);
            GRP_CNT_MODE: m_cm[ch]  = cm[23:0];       // top byte is not stored
            default:      ;
        endcase
    endtask

    task automatic check_reg(input reg_group_t g, input logic [1:0] ch, input logic [31:0] exp);
        @(negedge clk);
        regsel = {g, ch, 2'b00};
        @(negedge clk);                     // regout registered one cycle later
        if (regout !== exp) begin
            report_error($sformatf("%s ch%0d reads %h, expected %h", g.name(), ch, regout, exp));
        end
    endtask

    task automatic check_channel(input logic [1:0] ch);
        check_reg(GRP_SRC, ch, m_src[ch]);
        check_reg(GRP_DST, ch, m_dst[ch]);
        check_reg(GRP_CNT_MODE, ch, {8'd0, m_cm[ch]});
    endtask

    task automatic compare_memory(input string phase);
        for (int i = 0; i < 256; i++) begin
            if (mem_i.mem[i] !== exp_mem[i]) begin
                report_error($sformatf("%s: memory at %03h is %h, expected %h",
                                       phase, i * 4, mem_i.mem[i], exp_mem[i]));
            end
        end
    endtask

    // one served item on the reference side
    task automatic model_item(input logic [1:0] ch);
        logic [7:0]  mode;
        logic [31:0] n;
        mode = m_cm[ch][23:16];
        n    = (mode[1:0] == SZ_BYTE) ? 32'd1 : (mode[1:0] == SZ_WORD) ? 32'd2 : 32'd4;
        m_cm[ch][15:0] = m_cm[ch][15:0] - 16'd1;
        if (mode[4:2] == AM_COUNT) begin
            m_src[ch] = m_src[ch] + 32'd1;
        end else begin
            for (int k = 0; k < n; k++) put_byte(m_dst[ch] + k, get_byte(m_src[ch] + k));
            case (mode[4:2])
                AM_DST_INC: m_dst[ch] = m_dst[ch] + n;
                AM_DST_DEC: m_dst[ch] = m_dst[ch] - n;
                AM_SRC_INC: m_src[ch] = m_src[ch] + n;
                AM_SRC_DEC: m_src[ch] = m_src[ch] - n;
                default:    ;               // fixed and reserved modes
            endcase
        end
    endtask

    task automatic run_request(input logic [1:0] ch);
        logic [31:0] dst0;
        logic [3:0]  exp_end;
        logic        count_mode;
        dst0       = m_dst[ch];
        count_mode = m_cm[ch][20:18] == AM_COUNT;
        model_item(ch);
        exp_end = (m_cm[ch][15:0] == 16'd0) ? (4'b0001 << ch) : 4'b0000;
        @(negedge clk);
        clear_monitors();
        req = 4'b0001 << ch;
        @(negedge clk);
        req = '0;
        while (busy) @(negedge clk);        // falls after UPDATE
        if (count_mode && cyc_cycles != 0) begin
            report_error($sformatf("ch%0d COUNT mode ran %0d bus cycles", ch, cyc_cycles));
        end
        if (!count_mode && (wr_q.size() != 1 || wr_q[0] !== dst0)) begin
            report_error($sformatf("ch%0d saw %0d writes, expected one to %h",
                                   ch, wr_q.size(), dst0));
        end
        if (end_seen !== exp_end || end_cycles != ((exp_end != 0) ? 1 : 0)) begin
            report_error($sformatf("ch%0d dma_end %b for %0d cycles, expected %b",
                                   ch, end_seen, end_cycles, exp_end));
        end
    endtask

    initial begin
        entry_t e;
        int     order [4];
        rst = 1'b1;
        cen = 1'b1;
        regin = '0;
        regsel = '0;
        regwe = '0;
        int_inc = 1'b0;
        int_dec = 1'b0;
        req = '0;
        errors = 0;
        order = '{1, 0, 2, 3};              // ch1 first then pending ch0 jumps ahead
        clear_monitors();
        for (int c = 0; c < 4; c++) begin
            m_src[c] = '0;
            m_dst[c] = '0;
            m_cm[c]  = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < 256; i++) exp_mem[i] = mem_i.mem[i];

        // long, word and byte lanes
        write_reg(GRP_SRC, 2'd1, 2'd0, 3'b100, 32'h11223344);
        write_reg(GRP_SRC, 2'd1, 2'd2, 3'b010, 32'h0000aabb);
        write_reg(GRP_SRC, 2'd1, 2'd1, 3'b001, 32'h000000cc);
        write_reg(GRP_DST, 2'd2, 2'd0, 3'b010, 32'h00005566);
        write_reg(GRP_DST, 2'd2, 2'd3, 3'b001, 32'h00000077);
        write_reg(GRP_CNT_MODE, 2'd3, 2'd0, 3'b100, 32'hff12abcd);
        write_reg(GRP_CNT_MODE, 2'd3, 2'd2, 3'b001, 32'h0000003c);
        write_reg(GRP_CNT_MODE, 2'd3, 2'd1, 3'b001, 32'h00000099);
        for (int c = 0; c < 4; c++) check_channel(2'(c));

        // nesting counter goes +3 -1 then holds with both high
        @(negedge clk);
        int_inc = 1'b1;
        repeat (3) @(negedge clk);
        int_inc = 1'b0;
        int_dec = 1'b1;
        @(negedge clk);
        int_inc = 1'b1;
        @(negedge clk);
        int_inc = 1'b0;
        int_dec = 1'b0;
        check_reg(GRP_NEST, 2'd0, 32'd2);

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            e = table_entry(i);
            write_reg(GRP_SRC, e.ch, 2'd0, 3'b100, e.src);
            write_reg(GRP_DST, e.ch, 2'd0, 3'b100, e.dst);
            write_reg(GRP_CNT_MODE, e.ch, 2'd0, 3'b100, {8'd0, e.mode, e.cnt});
            repeat (e.nreq) run_request(e.ch);
            compare_memory($sformatf("entry %0d", i));
            check_channel(e.ch);
        end

        // priority test with one long item per channel
        for (int c = 0; c < 4; c++) begin
            write_reg(GRP_SRC, 2'(c), 2'd0, 3'b100, 32'h140 + 4 * c);
            write_reg(GRP_DST, 2'(c), 2'd0, 3'b100, 32'h2c0 + 8 * (3 - c));
            write_reg(GRP_CNT_MODE, 2'(c), 2'd0, 3'b100, 32'h00020001);
        end
        @(negedge clk);
        clear_monitors();
        req = 4'b1110;
        @(negedge clk);
        req = 4'b0001;                      // arrives while ch1 is in LOAD
        @(negedge clk);
        req = '0;
        while (wr_q.size() < 4 || busy) @(negedge clk);
        for (int k = 0; k < 4; k++) begin
            if (wr_q[k] !== m_dst[order[k]]) begin
                report_error($sformatf("write %0d went to %h, expected ch%0d at %h",
                                       k, wr_q[k], order[k], m_dst[order[k]]));
            end
            model_item(2'(order[k]));
        end
        if (end_seen !== 4'b1111 || end_cycles != 4) begin
            report_error($sformatf("dma_end %b over %0d cycles, expected all four once",
                                   end_seen, end_cycles));
        end
        compare_memory("priority");
        for (int c = 0; c < 4; c++) check_channel(2'(c));

        $display("error count: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+source
source/udma_reg_pkg.sv
source/udma_xfer_pkg.sv
source/udma_regs.sv
source/udma_engine.sv
source/udma_top.sv
bench/udma_mem_model.sv
bench/udma_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the micro-DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps \
    --top-module udma_tb -Mdir obj_dir -f sim.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vudma_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0
